//--- gpu_params.svh
`ifndef GPU_PARAMS_SVH
`define GPU_PARAMS_SVH

`define GPU_WORD_WIDTH      32
`define GPU_ADDRESS_WIDTH   16
`define GPU_RAM_DEPTH_LOG2  10
`define GPU_REG_COUNT       16
`define GPU_REG_INDEX_WIDTH 4

// Instruction word layout.
`define GPU_OPCODE_MSB      31
`define GPU_OPCODE_LSB      24
`define GPU_RD_MSB          23
`define GPU_RD_LSB          20
`define GPU_RS_MSB          19
`define GPU_RS_LSB          16
`define GPU_RT_MSB          15
`define GPU_RT_LSB          12
`define GPU_IMM_MSB         15  // The immediate overlaps rt.
`define GPU_IMM_LSB         0

`endif

//--- gpu_pkg.sv
`default_nettype none
`include "gpu_params.svh"

package gpu_pkg;

    typedef logic [`GPU_WORD_WIDTH-1:0]      word_t;
    typedef logic [`GPU_ADDRESS_WIDTH-1:0]   addr_t;     // Byte address.
    typedef logic [`GPU_REG_INDEX_WIDTH-1:0] reg_index_t;

    // Faulting opcode in the top byte, faulting pc below it.
    typedef logic [`GPU_OPCODE_MSB-`GPU_OPCODE_LSB+`GPU_ADDRESS_WIDTH:0] exc_data_t;

    typedef enum logic [`GPU_OPCODE_MSB-`GPU_OPCODE_LSB:0] {
        NOP  = 8'h00,
        LDI  = 8'h01,
        ADD  = 8'h02,
        SUB  = 8'h03,
        AND  = 8'h04,
        OR   = 8'h05,
        XOR  = 8'h06,
        SHL  = 8'h07,
        LD   = 8'h08,
        ST   = 8'h09,
        BNZ  = 8'h0A,
        HALT = 8'hFF
    } opcode_e;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        EXECUTE,
        LOAD_WAIT,
        STOPPED
    } seq_state_e;

endpackage

`default_nettype wire

//--- block_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "gpu_params.svh"

module block_ram import gpu_pkg::*; #(
    parameter int DEPTH_LOG2 = `GPU_RAM_DEPTH_LOG2
) (
    input  wire                  clock,
    input  wire                  write,
    input  wire [DEPTH_LOG2-1:0] address,   // Word index.
    input  wire word_t           write_data,
    output word_t                read_data
);

    word_t mem [0:(1 << DEPTH_LOG2)-1];

    always_ff @(posedge clock) begin
        if (write) begin
            mem[address] <= write_data;
        end
        read_data <= mem[address];  // Old contents on a write cycle.
    end

endmodule

`default_nettype wire

//--- shader_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "gpu_params.svh"

module shader_decode import gpu_pkg::*; (
    input  wire                                clock,
    input  wire                                rst,
    input  wire                                run,
    input  wire word_t                         instruction,
    input  wire                                stopped,
    input  wire                                branch_taken,
    input  wire addr_t                         branch_target,
    output addr_t                              pc,
    output opcode_e                            opcode,
    output reg_index_t                         rd,
    output reg_index_t                         rs,
    output reg_index_t                         rt,
    output logic [`GPU_IMM_MSB-`GPU_IMM_LSB:0] imm,
    output logic                               exec_strobe,
    output logic                               load_strobe,
    output logic                               halt_strobe,
    output logic                               illegal_strobe
);

    seq_state_e                               state;
    word_t                                    ir;       // Instruction register.
    logic [`GPU_OPCODE_MSB-`GPU_OPCODE_LSB:0] raw_op;
    logic                                     illegal;

    assign raw_op  = ir[`GPU_OPCODE_MSB:`GPU_OPCODE_LSB];
    assign illegal = !(raw_op inside {NOP, LDI, ADD, SUB, AND, OR, XOR, SHL, LD, ST, BNZ, HALT});
    assign opcode  = opcode_e'(raw_op);
    assign rd      = ir[`GPU_RD_MSB:`GPU_RD_LSB];
    assign rs      = ir[`GPU_RS_MSB:`GPU_RS_LSB];
    assign rt      = ir[`GPU_RT_MSB:`GPU_RT_LSB];
    assign imm     = ir[`GPU_IMM_MSB:`GPU_IMM_LSB];

    assign exec_strobe    = (state == EXECUTE);
    assign load_strobe    = (state == LOAD_WAIT);   // Load data is out of the RAM now.
    assign halt_strobe    = exec_strobe && (opcode == HALT);
    assign illegal_strobe = exec_strobe && illegal;

    always_ff @(posedge clock) begin
        if (state == DECODE) begin
            ir <= instruction;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= IDLE;
            pc    <= '0;
        end else if (!run) begin
            state <= IDLE;
            pc    <= '0;
        end else begin
            case (state)
                IDLE:      if (!stopped) state <= FETCH;
                FETCH:     state <= DECODE;   // The RAM sees pc this cycle.
                DECODE:    state <= EXECUTE;
                EXECUTE: begin
                    if (halt_strobe || illegal_strobe) begin
                        state <= STOPPED;     // pc keeps the stopping instruction.
                    end else begin
                        pc    <= branch_taken ? branch_target : pc + addr_t'(4);
                        state <= (opcode == LD) ? LOAD_WAIT : FETCH;
                    end
                end
                LOAD_WAIT: state <= FETCH;
                default:   state <= STOPPED;  // Left only when run falls.
            endcase
        end
    end

    // One instruction in flight.
    a_one_strobe: assert property (@(posedge clock) disable iff (rst)
        !(exec_strobe && load_strobe));

    // The result stage must be holding halted for as long as the core sits stopped.
    a_stopped_halted: assert property (@(posedge clock) disable iff (rst)
        (state == STOPPED) |-> stopped);

endmodule

`default_nettype wire

//--- shader_execute.sv
`timescale 1ns/1ps
`default_nettype none
`include "gpu_params.svh"

module shader_execute import gpu_pkg::*; (
    input  wire opcode_e                       opcode,
    input  wire reg_index_t                    rt,
    input  wire [`GPU_IMM_MSB-`GPU_IMM_LSB:0]  imm,
    input  wire word_t                         rs_value,
    input  wire word_t                         rt_value,
    input  wire word_t                         rd_value,
    input  wire                                exec_strobe,
    output word_t                              alu_value,
    output addr_t                              mem_address,
    output word_t                              mem_write_data,
    output logic                               mem_write,
    output logic                               branch_taken,
    output addr_t                              branch_target
);

    localparam int IMM_WIDTH = `GPU_IMM_MSB - `GPU_IMM_LSB + 1;

    word_t imm_sext;
    word_t eff_address;

    assign imm_sext = {{(`GPU_WORD_WIDTH - IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm};

    always_comb begin
        case (opcode)
            LDI:     alu_value = imm_sext;
            ADD:     alu_value = rs_value + rt_value;
            SUB:     alu_value = rs_value - rt_value;
            AND:     alu_value = rs_value & rt_value;
            OR:      alu_value = rs_value | rt_value;
            XOR:     alu_value = rs_value ^ rt_value;
            SHL:     alu_value = rs_value << rt;    // Shift count is the rt field itself.
            default: alu_value = '0;
        endcase
    end

    // Base plus signed offset for LD and ST.
    assign eff_address    = rs_value + imm_sext;
    assign mem_address    = eff_address[`GPU_ADDRESS_WIDTH-1:0];
    assign mem_write_data = rd_value;   // ST stores rd.
    assign mem_write      = exec_strobe && (opcode == ST);

    assign branch_taken  = exec_strobe && (opcode == BNZ) && (rs_value != '0);
    assign branch_target = imm;         // Absolute byte address.

    a_store_in_execute: assert final (!mem_write || exec_strobe);

endmodule

`default_nettype wire

//--- shader_result.sv
`timescale 1ns/1ps
`default_nettype none
`include "gpu_params.svh"

module shader_result import gpu_pkg::*; (
    input  wire             clock,
    input  wire             rst,
    input  wire             run,
    input  wire opcode_e    opcode,
    input  wire reg_index_t rd,
    input  wire reg_index_t rs,
    input  wire reg_index_t rt,
    input  wire addr_t      pc,
    input  wire word_t      alu_value,
    input  wire word_t      load_data,
    input  wire             exec_strobe,
    input  wire             load_strobe,
    input  wire             halt_strobe,
    input  wire             illegal_strobe,
    output word_t           rs_value,
    output word_t           rt_value,
    output word_t           rd_value,
    input  wire reg_index_t read_index,
    output word_t           read_value,
    output logic            halted,
    output logic            exception,
    output exc_data_t       exception_data
);

    word_t regs [`GPU_REG_COUNT];
    logic  alu_write;

    assign alu_write = exec_strobe && (opcode inside {LDI, ADD, SUB, AND, OR, XOR, SHL});

    assign rs_value   = regs[rs];
    assign rt_value   = regs[rt];
    assign rd_value   = regs[rd];
    assign read_value = regs[read_index];  // Host readback port.

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `GPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (load_strobe) begin
            regs[rd] <= load_data;
        end else if (alu_write) begin
            regs[rd] <= alu_value;
        end
    end

    always_ff @(posedge clock) begin
        if (rst || !run) begin
            halted         <= 1'b0;
            exception      <= 1'b0;
            exception_data <= '0;
        end else if (illegal_strobe) begin
            halted         <= 1'b1;
            exception      <= 1'b1;
            exception_data <= {opcode, pc};
        end else if (halt_strobe) begin
            halted         <= 1'b1;
        end
    end

    a_exc_halted: assert property (@(posedge clock) disable iff (rst) exception |-> halted);

endmodule

`default_nettype wire

//--- shader_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "gpu_params.svh"

module shader_core import gpu_pkg::*; (
    input  wire             clock,
    input  wire             rst,
    input  wire             run,
    output logic            halted,
    output logic            exception,
    output exc_data_t       exception_data,
    output addr_t           inst_ram_address,
    input  wire word_t      inst_ram_read_result,
    output addr_t           data_ram_address,
    output word_t           data_ram_write_data,
    output logic            data_ram_write,
    input  wire word_t      data_ram_read_result,
    input  wire reg_index_t reg_read_index,
    output word_t           reg_read_value
);

    opcode_e                            opcode;
    reg_index_t                         rd;
    reg_index_t                         rs;
    reg_index_t                         rt;
    logic [`GPU_IMM_MSB-`GPU_IMM_LSB:0] imm;
    logic                               exec_strobe;
    logic                               load_strobe;
    logic                               halt_strobe;
    logic                               illegal_strobe;
    word_t                              rs_value;
    word_t                              rt_value;
    word_t                              rd_value;
    word_t                              alu_value;
    logic                               branch_taken;
    addr_t                              branch_target;

    shader_decode decode_inst (
        .clock(clock), .rst(rst), .run(run),
        .instruction(inst_ram_read_result),
        .stopped(halted),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .pc(inst_ram_address),
        .opcode(opcode), .rd(rd), .rs(rs), .rt(rt), .imm(imm),
        .exec_strobe(exec_strobe), .load_strobe(load_strobe),
        .halt_strobe(halt_strobe), .illegal_strobe(illegal_strobe));

    shader_execute execute_inst (
        .opcode(opcode), .rt(rt), .imm(imm),
        .rs_value(rs_value), .rt_value(rt_value), .rd_value(rd_value),
        .exec_strobe(exec_strobe),
        .alu_value(alu_value),
        .mem_address(data_ram_address),
        .mem_write_data(data_ram_write_data),
        .mem_write(data_ram_write),
        .branch_taken(branch_taken), .branch_target(branch_target));

    shader_result result_inst (
        .clock(clock), .rst(rst), .run(run),
        .opcode(opcode), .rd(rd), .rs(rs), .rt(rt),
        .pc(inst_ram_address),
        .alu_value(alu_value), .load_data(data_ram_read_result),
        .exec_strobe(exec_strobe), .load_strobe(load_strobe),
        .halt_strobe(halt_strobe), .illegal_strobe(illegal_strobe),
        .rs_value(rs_value), .rt_value(rt_value), .rd_value(rd_value),
        .read_index(reg_read_index), .read_value(reg_read_value),
        .halted(halted), .exception(exception), .exception_data(exception_data));

endmodule

`default_nettype wire

//--- gpu.sv
`timescale 1ns/1ps
`default_nettype none
`include "gpu_params.svh"

module gpu import gpu_pkg::*; (
    input  wire             clock,
    input  wire             rst,
    input  wire             run,
    output logic            halted,
    output logic            exception,
    output exc_data_t       exception_data,

    input  wire             ext_enable_write_inst_ram,
    input  wire addr_t      ext_inst_ram_address,
    input  wire word_t      ext_inst_ram_input,
    output word_t           ext_inst_ram_output,

    input  wire             ext_enable_write_data_ram,
    input  wire addr_t      ext_data_ram_address,
    input  wire word_t      ext_data_ram_input,
    output word_t           ext_data_ram_output,

    input  wire reg_index_t ext_register_address,
    output word_t           ext_register_output
);

    localparam int RAM_AW = `GPU_RAM_DEPTH_LOG2;

    addr_t core_inst_address;
    addr_t core_data_address;
    word_t core_data_write_data;
    logic  core_data_write;

    addr_t inst_address;        // Byte address after the run mux.
    addr_t data_address;
    logic  inst_write;
    logic  data_write;
    word_t data_write_data;

    // The host owns both RAMs while run is low.
    assign inst_address    = run ? core_inst_address : ext_inst_ram_address;
    assign inst_write      = !run && ext_enable_write_inst_ram;
    assign data_address    = run ? core_data_address : ext_data_ram_address;
    assign data_write      = run ? core_data_write : ext_enable_write_data_ram;
    assign data_write_data = run ? core_data_write_data : ext_data_ram_input;

    block_ram #(.DEPTH_LOG2(RAM_AW)) inst_ram (
        .clock(clock),
        .write(inst_write),
        .address(inst_address[RAM_AW+1:2]),   // Drop the byte offset.
        .write_data(ext_inst_ram_input),
        .read_data(ext_inst_ram_output));

    block_ram #(.DEPTH_LOG2(RAM_AW)) data_ram (
        .clock(clock),
        .write(data_write),
        .address(data_address[RAM_AW+1:2]),
        .write_data(data_write_data),
        .read_data(ext_data_ram_output));

    shader_core core_inst (
        .clock(clock), .rst(rst), .run(run),
        .halted(halted), .exception(exception), .exception_data(exception_data),
        .inst_ram_address(core_inst_address),
        .inst_ram_read_result(ext_inst_ram_output),
        .data_ram_address(core_data_address),
        .data_ram_write_data(core_data_write_data),
        .data_ram_write(core_data_write),
        .data_ram_read_result(ext_data_ram_output),
        .reg_read_index(ext_register_address),
        .reg_read_value(ext_register_output));

endmodule

`default_nettype wire

//--- gpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gpu_tb import gpu_pkg::*; ();

    localparam int HALT_LIMIT = 2048;
    localparam int HOST_WORDS = 32;

    logic       clock = 1'b0;
    logic       rst;
    logic       run;
    logic       halted;
    logic       exception;
    exc_data_t  exception_data;
    logic       ext_enable_write_inst_ram;
    addr_t      ext_inst_ram_address;
    word_t      ext_inst_ram_input;
    word_t      ext_inst_ram_output;
    logic       ext_enable_write_data_ram;
    addr_t      ext_data_ram_address;
    word_t      ext_data_ram_input;
    word_t      ext_data_ram_output;
    reg_index_t ext_register_address;
    word_t      ext_register_output;

    string  records[$];     // Non-comment lines of the input file.
    string  test_name;
    int     test_errors;
    int     total_errors;
    int     tests_run;
    int     tests_failed;
    integer seed;
    logic   loaded;

    gpu gpu_inst (
        .clock(clock), .rst(rst), .run(run),
        .halted(halted), .exception(exception), .exception_data(exception_data),
        .ext_enable_write_inst_ram(ext_enable_write_inst_ram),
        .ext_inst_ram_address(ext_inst_ram_address),
        .ext_inst_ram_input(ext_inst_ram_input),
        .ext_inst_ram_output(ext_inst_ram_output),
        .ext_enable_write_data_ram(ext_enable_write_data_ram),
        .ext_data_ram_address(ext_data_ram_address),
        .ext_data_ram_input(ext_data_ram_input),
        .ext_data_ram_output(ext_data_ram_output),
        .ext_register_address(ext_register_address),
        .ext_register_output(ext_register_output));

    always #4 clock = ~clock;   // 8 ns period.

    task automatic show_mismatch(input string signal, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("FAIL %s: expected %h, got %h", signal, expected, actual);
        test_errors++;
    endtask

    task automatic complain(input string what);
        $display("Test %s: %s.", test_name, what);
        test_errors++;
    endtask

    function automatic string trim(input string s);
        string t;
        t = s;
        while (t.len() > 0 && (t.getc(t.len() - 1) inside {"\n", "\r", " "})) begin
            t = (t.len() == 1) ? "" : t.substr(0, t.len() - 2);
        end
        return t;
    endfunction

    task automatic write_ram(input logic inst, input addr_t address, input word_t value);
        @(posedge clock);
        if (inst) begin
            ext_enable_write_inst_ram <= 1'b1;
            ext_inst_ram_address      <= address;
            ext_inst_ram_input        <= value;
        end else begin
            ext_enable_write_data_ram <= 1'b1;
            ext_data_ram_address      <= address;
            ext_data_ram_input        <= value;
        end
        @(posedge clock);           // Strobe is taken on this edge.
        ext_enable_write_inst_ram <= 1'b0;
        ext_enable_write_data_ram <= 1'b0;
    endtask

    task automatic read_data_ram(input addr_t address, output word_t value);
        @(posedge clock);
        ext_data_ram_address <= address;
        @(posedge clock);           // RAM registers the word here.
        @(negedge clock);
        value = ext_data_ram_output;
    endtask

    task automatic read_inst_ram(input addr_t address, output word_t value);
        @(posedge clock);
        ext_inst_ram_address <= address;
        @(posedge clock);
        @(negedge clock);
        value = ext_inst_ram_output;
    endtask

    task automatic read_register(input reg_index_t index, output word_t value);
        @(posedge clock);
        ext_register_address <= index;
        @(negedge clock);
        value = ext_register_output;
    endtask

    // Dropping run must clear every status output one edge later.
    task automatic stop_core();
        if (run) begin
            @(posedge clock);
            run <= 1'b0;
            @(posedge clock);
            @(negedge clock);
            if (halted !== 1'b0) show_mismatch("halted", 32'h0, 32'(halted));
            if (exception !== 1'b0) show_mismatch("exception", 32'h0, 32'(exception));
            if (exception_data !== '0) show_mismatch("exception_data", 32'h0, 32'(exception_data));
        end
    endtask

    task automatic run_program();
        int cycles;
        stop_core();
        @(posedge clock);
        run <= 1'b1;
        cycles = 0;
        @(negedge clock);
        while (halted !== 1'b1 && cycles < HALT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (halted !== 1'b1) complain($sformatf("core did not halt within %0d cycles", HALT_LIMIT));
    endtask

    task automatic end_test();
        if (test_name != "") begin
            stop_core();
            tests_run++;
            total_errors += test_errors;
            if (test_errors == 0) begin
                $display("PASS test %s", test_name);
            end else begin
                tests_failed++;
                $display("FAIL test %s, %0d checks wrong", test_name, test_errors);
            end
        end
    endtask

    task automatic begin_test(input string name);
        end_test();
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic host_ram_test();
        word_t written [HOST_WORDS];
        word_t value;
        addr_t address;
        begin_test("host_ram");
        for (int i = 0; i < HOST_WORDS; i++) begin
            written[i] = $random(seed);
            write_ram(1'b0, addr_t'(16'h0200 + 4 * i), written[i]);
        end
        for (int i = 0; i < HOST_WORDS; i++) begin
            address = addr_t'(16'h0200 + 4 * i);
            read_data_ram(address, value);
            if (value !== written[i])
                show_mismatch($sformatf("ext_data_ram_output[%h]", address), written[i], value);
        end
    endtask

    task automatic do_record(input string line);
        byte         kind;
        string       rest;
        int          fields;
        logic [31:0] a;
        logic [31:0] b;
        word_t       value;
        kind = line.getc(0);
        rest = (line.len() > 2) ? line.substr(2, line.len() - 1) : "";
        a = '0;
        b = '0;
        fields = $sscanf(rest, "%h %h", a, b);
        case (kind)
            "T": begin_test(rest);
            "R": run_program();
            "I", "D": begin
                stop_core();        // Host writes only count with run low.
                write_ram(kind == "I", addr_t'(a), b);
                if (kind == "I") begin
                    read_inst_ram(addr_t'(a), value);
                    if (value !== b)
                        show_mismatch($sformatf("ext_inst_ram_output[%h]", a[15:0]), b, value);
                end
            end
            "M": begin
                stop_core();
                read_data_ram(addr_t'(a), value);
                if (value !== b)
                    show_mismatch($sformatf("ext_data_ram_output[%h]", a[15:0]), b, value);
            end
            "G": begin
                read_register(reg_index_t'(a), value);
                if (value !== b)
                    show_mismatch($sformatf("ext_register_output[%0d]", a[3:0]), b, value);
            end
            "X": begin
                if (halted !== 1'b1) show_mismatch("halted", 32'h1, 32'(halted));
                if (exception !== a[0]) show_mismatch("exception", a, 32'(exception));
                if (exception_data !== b[23:0])
                    show_mismatch("exception_data", b, 32'(exception_data));
            end
            default: complain($sformatf("unknown record '%s' (%0d fields)", line, fields));
        endcase
    endtask

    task automatic load_records();
        int    fd;
        string line;
        fd = $fopen("gpu_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open gpu_input.txt.");
            total_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0) begin
                    line = trim(line);
                    if (line.len() > 0 && line.getc(0) != "#") records.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin : watchdog
        longint limit_ns;
        wait (loaded === 1'b1);
        limit_ns = longint'(records.size() + HOST_WORDS) * 4 * 512 * 8;
        #(limit_ns);
        $display("Run timed out after %0d ns.", limit_ns);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        rst                       = 1'b1;
        run                       = 1'b0;
        ext_enable_write_inst_ram = 1'b0;
        ext_inst_ram_address      = '0;
        ext_inst_ram_input        = '0;
        ext_enable_write_data_ram = 1'b0;
        ext_data_ram_address      = '0;
        ext_data_ram_input        = '0;
        ext_register_address      = '0;
        seed                      = 32'hb5bcb89a;
        test_name                 = "";
        test_errors               = 0;
        total_errors              = 0;
        tests_run                 = 0;
        tests_failed              = 0;
        loaded                    = 1'b0;
        load_records();
        loaded = 1'b1;
        repeat (10) @(posedge clock);
        rst <= 1'b0;
        host_ram_test();
        foreach (records[i]) do_record(records[i]);
        end_test();
        $display("Tests run %0d, failed %0d, checks wrong %0d.",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0 && tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
gpu_pkg.sv
block_ram.sv
shader_decode.sv
shader_execute.sv
shader_result.sv
shader_core.sv
gpu.sv
gpu_tb.sv

//--- gpu_input.txt
# T name | I byte_addr word | D byte_addr word | R | M byte_addr expected
# G reg expected | X exception exception_data (all numbers hex)
T alu
I 0000 01101234
I 0004 01208001
I 0008 02312000
I 000C 03412000
I 0010 04534000
I 0014 05612000
I 0018 06734000
I 001C 07815000
I 0020 FF000000
R
X 0 000000
G 1 00001234
G 2 FFFF8001
G 3 FFFF9235
G 4 00009233
G 5 00009231
G 6 FFFF9235
G 7 FFFF0006
G 8 00024680
T load_store
D 0100 CAFEF00D
D 0104 0BADBEEF
D 00FC 13579BDF
I 0000 01100100
I 0004 08210004
I 0008 0831FFFC
I 000C 08410000
I 0010 09210020
I 0014 0931FFF0
I 0018 09410024
I 001C FF000000
R
X 0 000000
G 2 0BADBEEF
G 3 13579BDF
G 4 CAFEF00D
M 0120 0BADBEEF
M 00F0 13579BDF
M 0124 CAFEF00D
M 0100 CAFEF00D
T branch_loop
I 0000 0110000A
I 0004 01200000
I 0008 01300001
I 000C 02221000
I 0010 03113000
I 0014 0A01000C
I 0018 FF000000
R
X 0 000000
G 1 00000000
G 2 00000037
G 3 00000001
T illegal_opcode
I 0000 01900042
I 0004 00000000
I 0008 5A000000
I 000C 01900077
I 0010 FF000000
R
X 1 5A0008
G 9 00000042
